// File: source/i2cPkg.sv
// ######################################################################
// shared constants and types for the I2C controller
// scl rate is fixed at build time through QUARTER_PERIOD
// ######################################################################

package i2cPkg;

    // register bus and byte widths
    localparam int DATA_WIDTH    = 32;
    localparam int BYTE_WIDTH    = 8;
    localparam int COMMAND_WIDTH = 2;

    // commands carried in the data register
    localparam logic [COMMAND_WIDTH-1:0] CMD_START = 2'd0;
    localparam logic [COMMAND_WIDTH-1:0] CMD_STOP  = 2'd1;
    localparam logic [COMMAND_WIDTH-1:0] CMD_WRITE = 2'd2;
    localparam logic [COMMAND_WIDTH-1:0] CMD_READ  = 2'd3;

    // data register fields
    localparam int COMMAND_LSB = 9;
    localparam int ACK_BIT     = 8;
    localparam int DATA_LSB    = 0;

    // register addresses
    localparam logic ADDR_DATA   = 1'b0;
    localparam logic ADDR_STATUS = 1'b1;

    // status register bits
    localparam int TRANSMIT_READY_BIT = 0;
    localparam int RECEIVE_VALID_BIT  = 1;

    // system clocks per quarter scl period
    // 125 MHz / (4 * 25) gives 1.25 MHz scl
    localparam logic [15:0] QUARTER_PERIOD = 16'd25;

    // operations of the bit engine
    typedef enum logic [1:0] {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bitOpType;

endpackage

// File: source/i2cBitEngine.sv
// ######################################################################
// one start, stop or data bit in four quarter periods on open-drain lines
// the high phase waits for scl to rise, so targets may stretch the clock
// ######################################################################

module i2cBitEngine (
    input  logic             clk,
    input  logic             reset,
    input  i2cPkg::bitOpType bitOp,
    input  logic             bitIn,
    input  logic             bitStart,

    output logic             bitOut,
    output logic             bitDone,

    inout  wire              scl,
    inout  wire              sda
);

    import i2cPkg::*;

    logic                               busy;
    logic [1:0]                         phase;
    logic [1:0]                         nextPhase;
    logic [$bits(QUARTER_PERIOD)-1:0]   count;
    bitOpType                           opReg;
    bitOpType                           op;

    // a one releases the line
    logic                               sclOut;
    logic                               sdaOut;
    logic                               sclNext;
    logic                               sdaNext;

    logic [1:0]                         sclSync;
    logic [1:0]                         sdaSync;
    logic                               stretch;
    logic                               quarterEnd;

    assign scl = sclOut ? 1'bz : 1'b0;
    assign sda = sdaOut ? 1'bz : 1'b0;

    // bus lines into the clock domain
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sclSync <= 2'b11;
            sdaSync <= 2'b11;
        end else begin
            sclSync <= {sclSync[0], scl};
            sdaSync <= {sdaSync[0], sda};
        end
    end

    // released but still low means a target holds scl
    assign stretch    = sclOut && !sclSync[1];
    assign quarterEnd = (count == QUARTER_PERIOD - 1'b1);

    // operation and phase about to be entered
    assign op        = busy ? opReg : bitOp;
    assign nextPhase = busy ? phase + 2'd1 : 2'd0;

    // line levels on phase entry build on the phase before
    always_comb begin
        sclNext = sclOut;
        sdaNext = sdaOut;
        case (op)
            BIT_START: begin
                case (nextPhase)
                    // scl left as is for a repeated start
                    2'd0: sdaNext = 1'b1;
                    2'd1: sclNext = 1'b1;
                    2'd2: sdaNext = 1'b0;
                    default: sclNext = 1'b0;
                endcase
            end
            BIT_STOP: begin
                case (nextPhase)
                    2'd0: sdaNext = 1'b0;
                    2'd1: sclNext = 1'b1;
                    2'd2: sdaNext = 1'b1;
                    default: ;
                endcase
            end
            default: begin
                case (nextPhase)
                    2'd0: begin
                        sclNext = 1'b0;
                        sdaNext = (op == BIT_READ) ? 1'b1 : bitIn;
                    end
                    2'd1: sclNext = 1'b1;
                    2'd2: ;
                    default: sclNext = 1'b0;
                endcase
            end
        endcase
    end

    // phase sequencer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy    <= 1'b0;
            phase   <= 2'd0;
            count   <= '0;
            opReg   <= BIT_START;
            sclOut  <= 1'b1;
            sdaOut  <= 1'b1;
            bitOut  <= 1'b0;
            bitDone <= 1'b0;
        end else begin
            bitDone <= 1'b0;
            if (!busy) begin
                if (bitStart) begin
                    busy   <= 1'b1;
                    phase  <= 2'd0;
                    count  <= '0;
                    opReg  <= bitOp;
                    sclOut <= sclNext;
                    sdaOut <= sdaNext;
                end
            end else if (!stretch) begin
                if (quarterEnd) begin
                    count <= '0;
                    if (phase == 2'd3) begin
                        busy    <= 1'b0;
                        bitDone <= 1'b1;
                    end else begin
                        phase  <= nextPhase;
                        sclOut <= sclNext;
                        sdaOut <= sdaNext;
                        // middle of the high phase
                        if (nextPhase == 2'd2) begin
                            bitOut <= sdaSync[1];
                        end
                    end
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

// File: source/i2cCore.sv
// ######################################################################
// byte sequencer, one command at a time, commands while busy are dropped
// no arbitration, a lost bus is not detected
// ######################################################################

module i2cCore (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [i2cPkg::COMMAND_WIDTH-1:0] commandIn,
    input  logic [i2cPkg::BYTE_WIDTH-1:0]    transmitDataIn,
    input  logic                             transmitAckIn,
    input  logic                             transmitDataLoadEn,
    input  logic                             receiveDataReadReq,

    output logic [i2cPkg::BYTE_WIDTH-1:0]    receiveData,
    output logic                             receiveAck,
    output logic                             receiveValid,
    output logic                             transmitReady,

    inout  wire                              scl,
    inout  wire                              sda
);

    import i2cPkg::*;

    localparam int COUNT_WIDTH = $clog2(BYTE_WIDTH);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SINGLE,
        ST_BYTE,
        ST_ACK
    } stateType;

    stateType                 state;
    logic [COMMAND_WIDTH-1:0] commandReg;
    logic [COUNT_WIDTH-1:0]   bitCount;
    logic [BYTE_WIDTH-1:0]    shiftReg;
    logic                     ackOutReg;

    // bit engine handshake
    bitOpType                 bitOp;
    logic                     bitIn;
    logic                     bitStart;
    logic                     bitOut;
    logic                     bitDone;

    logic                     loadAccept;
    logic                     byteBitDone;
    logic                     ackDone;
    logic                     lastBit;
    logic                     isRead;

    assign loadAccept  = transmitDataLoadEn && (state == ST_IDLE);
    assign byteBitDone = (state == ST_BYTE) && bitDone;
    assign ackDone     = (state == ST_ACK) && bitDone;
    assign lastBit     = (bitCount == '0);
    assign isRead      = (commandReg == CMD_READ);

    // command sequencer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            commandReg    <= CMD_START;
            bitCount      <= '0;
            bitOp         <= BIT_START;
            bitStart      <= 1'b0;
            transmitReady <= 1'b1;
        end else begin
            bitStart <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (transmitDataLoadEn) begin
                        commandReg    <= commandIn;
                        bitCount      <= COUNT_WIDTH'(BYTE_WIDTH - 1);
                        bitStart      <= 1'b1;
                        transmitReady <= 1'b0;
                        case (commandIn)
                            CMD_START: begin
                                bitOp <= BIT_START;
                                state <= ST_SINGLE;
                            end
                            CMD_STOP: begin
                                bitOp <= BIT_STOP;
                                state <= ST_SINGLE;
                            end
                            CMD_WRITE: begin
                                bitOp <= BIT_WRITE;
                                state <= ST_BYTE;
                            end
                            default: begin
                                bitOp <= BIT_READ;
                                state <= ST_BYTE;
                            end
                        endcase
                    end
                end
                ST_SINGLE: begin
                    if (bitDone) begin
                        state         <= ST_IDLE;
                        transmitReady <= 1'b1;
                    end
                end
                ST_BYTE: begin
                    if (bitDone) begin
                        bitStart <= 1'b1;
                        if (lastBit) begin
                            // ninth bit goes the other way
                            state <= ST_ACK;
                            bitOp <= isRead ? BIT_WRITE : BIT_READ;
                        end else begin
                            bitCount <= bitCount - 1'b1;
                        end
                    end
                end
                ST_ACK: begin
                    if (bitDone) begin
                        state         <= ST_IDLE;
                        transmitReady <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // shifter, MSB first in both directions
    always_ff @(posedge clk) begin
        if (loadAccept) begin
            // a read shifts in behind ones so sda stays released
            shiftReg  <= (commandIn == CMD_READ) ? '1 : transmitDataIn;
            bitIn     <= (commandIn == CMD_READ) ? 1'b1 : transmitDataIn[BYTE_WIDTH-1];
            ackOutReg <= transmitAckIn;
        end else if (byteBitDone) begin
            shiftReg <= {shiftReg[BYTE_WIDTH-2:0], bitOut};
            if (lastBit) begin
                bitIn <= isRead ? ackOutReg : 1'b1;
            end else begin
                bitIn <= shiftReg[BYTE_WIDTH-2];
            end
        end
    end

    // results seen by software
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            receiveData  <= '0;
            receiveAck   <= 1'b0;
            receiveValid <= 1'b0;
        end else begin
            if (byteBitDone && lastBit) begin
                receiveData <= {shiftReg[BYTE_WIDTH-2:0], bitOut};
            end
            // ack as seen on the bus
            if (ackDone) begin
                receiveAck <= bitOut;
            end
            if (receiveDataReadReq) begin
                receiveValid <= 1'b0;
            end else if (ackDone) begin
                receiveValid <= 1'b1;
            end
        end
    end

    i2cBitEngine bitEngine (
        .clk      (clk),
        .reset    (reset),
        .bitOp    (bitOp),
        .bitIn    (bitIn),
        .bitStart (bitStart),
        .bitOut   (bitOut),
        .bitDone  (bitDone),
        .scl      (scl),
        .sda      (sda)
    );

endmodule

// File: source/i2c.sv
// ######################################################################
// register front end of the I2C controller, two words, fixed read latency
// software polls transmitReady before writing a command
// ######################################################################

// address 0: data register {command, ack, byte}, command is write only
// address 1: status register {receiveValid, transmitReady}, read only

module i2c (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          read,
    input  logic                          write,
    input  logic                          address,
    input  logic [i2cPkg::DATA_WIDTH-1:0] dataIn,

    output logic                          readValid,
    output logic [i2cPkg::DATA_WIDTH-1:0] dataOut,

    inout  wire                           scl,
    inout  wire                           sda
);

    import i2cPkg::*;

    // registered bus inputs
    logic                  readReg;
    logic                  writeReg;
    logic                  addressReg;
    logic [DATA_WIDTH-1:0] dataInReg;
    logic [DATA_WIDTH-1:0] readMux;

    // core interface
    logic                  transmitDataLoadEn;
    logic                  receiveDataReadReq;
    logic [BYTE_WIDTH-1:0] receiveData;
    logic                  receiveAck;
    logic                  receiveValid;
    logic                  transmitReady;

    // strobes and address
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readReg    <= 1'b0;
            writeReg   <= 1'b0;
            addressReg <= ADDR_DATA;
            readValid  <= 1'b0;
        end else begin
            readReg    <= read;
            writeReg   <= write;
            addressReg <= address;
            readValid  <= readReg;
        end
    end

    // write data in, read data out
    always_ff @(posedge clk) begin
        dataInReg <= dataIn;
        dataOut   <= readMux;
    end

    // only the data address takes writes
    assign transmitDataLoadEn = writeReg && (addressReg == ADDR_DATA);

    // a data read hands the byte to software and clears receiveValid
    assign receiveDataReadReq = readReg && (addressReg == ADDR_DATA);

    // read mux
    always_comb begin
        readMux = '0;
        case (addressReg)
            ADDR_DATA: begin
                readMux[DATA_LSB +: BYTE_WIDTH] = receiveData;
                readMux[ACK_BIT]                = receiveAck;
            end
            ADDR_STATUS: begin
                readMux[TRANSMIT_READY_BIT] = transmitReady;
                readMux[RECEIVE_VALID_BIT]  = receiveValid;
            end
            default: ;
        endcase
    end

    i2cCore core (
        .clk                (clk),
        .reset              (reset),
        .commandIn          (dataInReg[COMMAND_LSB +: COMMAND_WIDTH]),
        .transmitDataIn     (dataInReg[DATA_LSB +: BYTE_WIDTH]),
        .transmitAckIn      (dataInReg[ACK_BIT]),
        .transmitDataLoadEn (transmitDataLoadEn),
        .receiveDataReadReq (receiveDataReadReq),
        .receiveData        (receiveData),
        .receiveAck         (receiveAck),
        .receiveValid       (receiveValid),
        .transmitReady      (transmitReady),
        .scl                (scl),
        .sda                (sda)
    );

endmodule

// File: bench/i2cTargetModel.sv
// ######################################################################
// behavioral I2C target, 7-bit address, four-byte memory
// first byte after a write address sets the pointer, never stretches scl
// ######################################################################

module i2cTargetModel #(
    parameter logic [6:0] ADDRESS = 7'h50
) (
    inout wire scl,
    inout wire sda
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEMORY_SIZE = 4;

    logic [7:0] memory [MEMORY_SIZE];
    logic [1:0] pointer;
    logic [7:0] shiftIn;
    logic [7:0] shiftOut;
    logic       sdaLow;
    logic       active;
    logic       readMode;
    logic       controllerAck;
    int         bitCount;
    int         byteCount;

    assign sda = sdaLow ? 1'b0 : 1'bz;

    initial begin
        sdaLow        = 1'b0;
        active        = 1'b0;
        readMode      = 1'b0;
        controllerAck = 1'b0;
        pointer       = '0;
        bitCount      = 0;
        byteCount     = 0;
        for (int i = 0; i < MEMORY_SIZE; i++) begin
            memory[i] = 8'(i) ^ 8'h3C;
        end
    end

    // address, pointer or data byte just shifted in
    task takeByte;
        if (byteCount == 0) begin
            if (shiftIn[7:1] == ADDRESS) begin
                readMode = shiftIn[0];
                sdaLow   = 1'b1;
            end else begin
                // not ours, wait for the next start
                active = 1'b0;
            end
        end else if (byteCount == 1) begin
            pointer = shiftIn[1:0];
            sdaLow  = 1'b1;
        end else begin
            memory[pointer] = shiftIn;
            pointer         = pointer + 1'b1;
            sdaLow          = 1'b1;
        end
    endtask

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active    = 1'b1;
            readMode  = 1'b0;
            bitCount  = 0;
            byteCount = 0;
            sdaLow    = 1'b0;
        end
    end

    // stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active   = 1'b0;
            readMode = 1'b0;
            sdaLow   = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (bitCount < 8) begin
                shiftIn = {shiftIn[6:0], (sda !== 1'b0)};
            end else begin
                controllerAck = (sda === 1'b0);
            end
            bitCount++;
        end
    end

    // sda only changes while scl is low
    always @(negedge scl) begin
        if (active) begin
            if (bitCount == 8) begin
                if (readMode) begin
                    sdaLow = 1'b0;
                end else begin
                    takeByte();
                end
            end else if (bitCount == 9) begin
                sdaLow    = 1'b0;
                bitCount  = 0;
                byteCount++;
                // keep sending until the controller answers with a nack
                if (readMode && (byteCount == 1 || controllerAck)) begin
                    shiftOut = memory[pointer];
                    pointer  = pointer + 1'b1;
                    sdaLow   = !shiftOut[7];
                end
            end else if (readMode && bitCount > 0) begin
                sdaLow = !shiftOut[7 - bitCount];
            end
        end
    end

endmodule

// File: bench/i2cTb.sv
// ######################################################################
// testbench for the I2C controller against one behavioral target
// stops at the first mismatch and a watchdog bounds the run
// ######################################################################

module i2cTb;
    timeunit 1ns;
    timeprecision 100ps;

    import i2cPkg::*;

    localparam logic [6:0] TARGET_ADDRESS = 7'h50;
    localparam int ROWS = 19;
    // ten bit times per row at most, plus margin for the register reads
    localparam int WATCHDOG_NS = ROWS * 10 * 4 * QUARTER_PERIOD * 8 + 20000;
    localparam logic [DATA_WIDTH-1:0] READY = DATA_WIDTH'(1) << TRANSMIT_READY_BIT;
    localparam logic [DATA_WIDTH-1:0] VALID = DATA_WIDTH'(1) << RECEIVE_VALID_BIT;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  read;
    logic                  write;
    logic                  address;
    logic [DATA_WIDTH-1:0] dataIn;
    logic                  readValid;
    logic [DATA_WIDTH-1:0] dataOut;
    wire                   scl;
    wire                   sda;

    // one bus command per row
    logic [COMMAND_WIDTH-1:0] rowCommand [ROWS];
    logic [BYTE_WIDTH-1:0]    rowData [ROWS];
    logic                     rowAck [ROWS];
    logic                     rowExpectAck [ROWS];
    logic [BYTE_WIDTH-1:0]    rowExpectData [ROWS];
    string                    rowName [ROWS];
    int                       rowCount = 0;
    logic [BYTE_WIDTH-1:0]    randomByte [3];

    pullup (scl);
    pullup (sda);

    always #4 clk = ~clk;

    i2c DUT (
        .clk       (clk),
        .reset     (reset),
        .read      (read),
        .write     (write),
        .address   (address),
        .dataIn    (dataIn),
        .readValid (readValid),
        .dataOut   (dataOut),
        .scl       (scl),
        .sda       (sda)
    );

    i2cTargetModel #(.ADDRESS(TARGET_ADDRESS)) target (
        .scl (scl),
        .sda (sda)
    );

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input string testName, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("FAIL %s expected %h actual %h",
                                      testName, expected, actual));
        end
    endtask

    task automatic checkBit(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("FAIL %s expected %b actual %b",
                                      testName, expected, actual));
        end
    endtask

    task automatic addRow(input logic [COMMAND_WIDTH-1:0] command,
                          input logic [BYTE_WIDTH-1:0] data, input logic ack,
                          input logic expectAck, input logic [BYTE_WIDTH-1:0] expectData,
                          input string name);
        rowCommand[rowCount]    = command;
        rowData[rowCount]       = data;
        rowAck[rowCount]        = ack;
        rowExpectAck[rowCount]  = expectAck;
        rowExpectData[rowCount] = expectData;
        rowName[rowCount]       = name;
        rowCount++;
    endtask

    task automatic buildTable();
        logic [BYTE_WIDTH-1:0] addrWrite;
        logic [BYTE_WIDTH-1:0] addrRead;
        addrWrite = {TARGET_ADDRESS, 1'b0};
        addrRead  = {TARGET_ADDRESS, 1'b1};
        addRow(CMD_START, 8'h00, 1'b0, 1'b0, 8'h00, "first start");
        addRow(CMD_WRITE, addrWrite, 1'b0, 1'b0, 8'h00, "address write ack");
        addRow(CMD_START, 8'h00, 1'b0, 1'b0, 8'h00, "repeated start");
        addRow(CMD_WRITE, 8'hB0, 1'b0, 1'b1, 8'h00, "absent address nack");
        addRow(CMD_START, 8'h00, 1'b0, 1'b0, 8'h00, "start for data");
        addRow(CMD_WRITE, addrWrite, 1'b0, 1'b0, 8'h00, "address for data");
        addRow(CMD_WRITE, 8'h00, 1'b0, 1'b0, 8'h00, "pointer byte");
        for (int i = 0; i < 3; i++) begin
            addRow(CMD_WRITE, randomByte[i], 1'b0, 1'b0, 8'h00,
                   $sformatf("data write %0d", i));
        end
        // rewind the pointer, then read back
        addRow(CMD_START, 8'h00, 1'b0, 1'b0, 8'h00, "start for rewind");
        addRow(CMD_WRITE, addrWrite, 1'b0, 1'b0, 8'h00, "address for rewind");
        addRow(CMD_WRITE, 8'h00, 1'b0, 1'b0, 8'h00, "pointer rewind");
        addRow(CMD_START, 8'h00, 1'b0, 1'b0, 8'h00, "repeated start read");
        addRow(CMD_WRITE, addrRead, 1'b0, 1'b0, 8'h00, "address read ack");
        for (int i = 0; i < 3; i++) begin
            addRow(CMD_READ, 8'h00, (i == 2), (i == 2), randomByte[i],
                   $sformatf("data read %0d", i));
        end
        addRow(CMD_STOP, 8'h00, 1'b0, 1'b0, 8'h00, "stop");
    endtask

    task automatic busWrite(input logic addr, input logic [DATA_WIDTH-1:0] data);
        @(negedge clk);
        write   = 1'b1;
        address = addr;
        dataIn  = data;
        @(negedge clk);
        write = 1'b0;
    endtask

    // readValid must come back exactly two cycles after the strobe
    task automatic busRead(input string testName, input logic addr,
                           output logic [DATA_WIDTH-1:0] data);
        int cycles;
        @(negedge clk);
        read    = 1'b1;
        address = addr;
        cycles  = 0;
        do begin
            @(negedge clk);
            read = 1'b0;
            cycles++;
        end while (readValid !== 1'b1 && cycles < 8);
        if (readValid !== 1'b1) begin
            stopWithFailure($sformatf("readValid never came back during %s", testName));
        end
        checkWord({testName, " read latency"}, 2, cycles);
        data = dataOut;
    endtask

    task automatic runCommand(input int row, output logic [DATA_WIDTH-1:0] status);
        logic [DATA_WIDTH-1:0] word;
        word = '0;
        word[COMMAND_LSB +: COMMAND_WIDTH] = rowCommand[row];
        word[ACK_BIT]                      = rowAck[row];
        word[DATA_LSB +: BYTE_WIDTH]       = rowData[row];
        busWrite(ADDR_DATA, word);
        do begin
            busRead(rowName[row], ADDR_STATUS, status);
        end while (status[TRANSMIT_READY_BIT] !== 1'b1);
    endtask

    initial begin
        logic [DATA_WIDTH-1:0] word;
        logic [DATA_WIDTH-1:0] expectWord;
        logic                  isByte;
        reset   = 1'b1;
        read    = 1'b0;
        write   = 1'b0;
        address = ADDR_DATA;
        dataIn  = '0;
        void'($urandom(93));
        for (int i = 0; i < 3; i++) begin
            randomByte[i] = BYTE_WIDTH'($urandom);
        end
        buildTable();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        busRead("status after reset", ADDR_STATUS, word);
        checkWord("status after reset", READY, word);
        busRead("data after reset", ADDR_DATA, word);
        checkWord("data after reset", '0, word);

        for (int row = 0; row < ROWS; row++) begin
            isByte = (rowCommand[row] == CMD_WRITE) || (rowCommand[row] == CMD_READ);
            runCommand(row, word);
            checkWord({rowName[row], " status"}, isByte ? (READY | VALID) : READY, word);
            if (isByte) begin
                // a status write leaves both flags as they are
                busWrite(ADDR_STATUS, '1);
                busRead(rowName[row], ADDR_STATUS, word);
                checkWord({rowName[row], " status write ignored"}, READY | VALID, word);
                busRead(rowName[row], ADDR_DATA, word);
                checkBit({rowName[row], " ack"}, rowExpectAck[row], word[ACK_BIT]);
                if (rowCommand[row] == CMD_READ) begin
                    expectWord = '0;
                    expectWord[DATA_LSB +: BYTE_WIDTH] = rowExpectData[row];
                    expectWord[ACK_BIT]                = rowExpectAck[row];
                    checkWord({rowName[row], " data"}, expectWord, word);
                end
                // the data read clears receiveValid
                busRead(rowName[row], ADDR_STATUS, word);
                checkWord({rowName[row], " valid cleared"}, READY, word);
            end
        end

        busWrite(ADDR_STATUS, '1);
        busRead("status write ignored", ADDR_STATUS, word);
        checkWord("status write ignored", READY, word);
        checkBit("scl released", 1'b1, scl);
        checkBit("sda released", 1'b1, sda);
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stopWithFailure("watchdog expired before the command table finished");
    end

endmodule

// File: flist.f
source/i2cPkg.sv
source/i2cBitEngine.sv
source/i2cCore.sv
source/i2c.sv
bench/i2cTargetModel.sv
bench/i2cTb.sv

// File: Bender.yml
package:
  name: i2c

sources:
  - files:
      - source/i2cPkg.sv
      - source/i2cBitEngine.sv
      - source/i2cCore.sv
      - source/i2c.sv
  - target: simulation
    files:
      - bench/i2cTargetModel.sv
      - bench/i2cTb.sv
